//--- cache_mem.f
rtl/cache_pkg.sv
rtl/gen_sram.sv
rtl/cache_valid_array.sv
rtl/cache_mem.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
verif/cache_tb.sv

//--- rtl/cache_ctrl.sv
// ************************************************************
// Cache controller FSM: lookup, line fill, write-through, evict.
// Drives the datapath strobes and the memory request port.
// ************************************************************

`timescale 1ns/100ps

module cache_ctrl
	import cache_pkg::*;
#(
	parameter int BK = 4
) (
	input  logic             CLK,
	input  logic             rst_n,
	input  logic             rd,
	input  logic             wr,
	input  logic             evict,
	input  addr_t            addr,
	input  word_t            wdata,
	input  strb_t            wstrb,
	input  logic             tag_hit,
	input  addr_t            line_addr,
	input  logic             mem_ack,
	input  logic [32*BK-1:0] mem_rdata,
	output logic             busy,
	output logic             done,
	output logic             hit,
	output logic             lookup,
	output logic             word_we,
	output logic             fill_we,
	output logic [32*BK-1:0] fill_data,
	output logic             mem_rd,
	output logic             mem_wr,
	output addr_t            mem_addr,
	output word_t            mem_wdata,
	output strb_t            mem_wstrb,
	output addr_t            req_addr,
	output word_t            req_wdata,
	output strb_t            req_wstrb,
	output logic             mem_evict
);

	cache_state_e     state;
	cache_state_e     state_d;
	logic             accept;
	logic             op_wr;
	addr_t            addr_q;
	word_t            wdata_q;
	strb_t            wstrb_q;
	logic [32*BK-1:0] line_q;

	// Strobes are ignored while busy.
	assign accept    = (rd | wr) & ~busy;
	assign mem_evict = evict & ~busy;

	// Live address while idle, latched one while busy.
	assign req_addr  = busy ? addr_q : addr;
	assign req_wdata = wdata_q;
	assign req_wstrb = wstrb_q;

	// Read issued on accept; RESP re-reads so rdata lands with done.
	assign lookup  = accept | ((state == ST_RESP) & ~op_wr);
	assign word_we = (state == ST_LOOKUP) & op_wr & tag_hit;
	assign fill_we = (state == ST_FILL_WRITE);
	assign fill_data = line_q;

	// One memory request per miss or write.
	assign mem_rd    = (state == ST_FILL_REQ);
	assign mem_wr    = (state == ST_LOOKUP) & op_wr;
	assign mem_addr  = op_wr ? {addr_q[31:2], 2'b00} : line_addr;
	assign mem_wdata = wdata_q;
	assign mem_wstrb = wstrb_q;

	// Next state.
	always_comb begin
		state_d = state;
		case (state)
			ST_IDLE:       if (accept) state_d = ST_LOOKUP;
			ST_LOOKUP: begin
				if (op_wr) begin
					state_d = ST_WT_WAIT;
				end else if (tag_hit) begin
					state_d = ST_RESP;
				end else begin
					state_d = ST_FILL_REQ;
				end
			end
			ST_FILL_REQ:   state_d = ST_FILL_WAIT;
			ST_FILL_WAIT:  if (mem_ack) state_d = ST_FILL_WRITE;
			ST_FILL_WRITE: state_d = ST_RESP;
			ST_WT_WAIT:    if (mem_ack) state_d = ST_RESP;
			ST_RESP:       state_d = ST_IDLE;
			default:       state_d = ST_IDLE;
		endcase
	end

	// Control registers.
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			busy  <= 1'b0;
			done  <= 1'b0;
			hit   <= 1'b0;
			op_wr <= 1'b0;
		end else begin
			state <= state_d;
			done  <= (state == ST_RESP);
			// Busy drops the cycle after done.
			if (accept) begin
				busy  <= 1'b1;
				op_wr <= wr;
			end else if (done) begin
				busy <= 1'b0;
			end
			// Hit comes from the first lookup only.
			if (state == ST_LOOKUP) begin
				hit <= tag_hit;
			end
		end
	end

	// Request payload.
	always_ff @(posedge CLK) begin
		if (accept) begin
			addr_q  <= addr;
			wdata_q <= wdata;
			wstrb_q <= wstrb;
		end
		// Fill line captured on ack.
		if ((state == ST_FILL_WAIT) && mem_ack) begin
			line_q <= mem_rdata;
		end
	end

endmodule

//--- rtl/cache_mem.sv
// ************************************************************
// Cache datapath: tag SRAM, word banks and valid bits.
// Driven by the controller; returns hit, word and line address.
// ************************************************************

`timescale 1ns/100ps

module cache_mem
	import cache_pkg::*;
#(
	parameter int BK = 4,
	parameter int CL = 16
) (
	input  logic            CLK,
	input  logic            rst_n,
	input  addr_t           addr,
	input  logic            lookup,
	input  logic            word_we,
	input  word_t           wdata,
	input  strb_t           wstrb,
	input  logic            fill_we,
	input  logic [32*BK-1:0] fill_data,
	input  logic            evict,
	output logic            tag_hit,
	output word_t           rdata,
	output addr_t           line_addr
);

	// Field widths from the line geometry.
	localparam int BSW = $clog2(BK);
	localparam int IW  = $clog2(CL);
	localparam int OFS = 2 + BSW;
	localparam int TW  = 32 - OFS - IW;

	logic [BSW-1:0] bank_sel;
	logic [IW-1:0]  index;
	logic [TW-1:0]  tag;
	logic [BSW-1:0] bank_sel_q;
	logic [TW-1:0]  tag_q;
	logic [TW-1:0]  tag_r;
	logic           valid_q;
	word_t          bank_r [BK];

	// Address split.
	assign bank_sel  = addr[2 +: BSW];
	assign index     = addr[OFS +: IW];
	assign tag       = addr[31 -: TW];
	assign line_addr = {addr[31:OFS], {OFS{1'b0}}};

	// Tag SRAM, written only on line fill.
	gen_sram #(
		.DW(TW),
		.AW(IW)
	) tag_ram (
		.CLK        (CLK),
		.data_w     (tag),
		.addr_w     (index),
		.data_wstrb ({((TW+7)/8){1'b1}}),
		.en_w       (fill_we),
		.addr_r     (index),
		.en_r       (lookup),
		.data_r     (tag_r)
	);

	// One SRAM per word of the line.
	for (genvar j = 0; j < BK; j++) begin : g_bank
		gen_sram #(
			.DW(32),
			.AW(IW)
		) data_bank_ram (
			.CLK        (CLK),
			.data_w     (fill_we ? fill_data[32*j +: 32] : wdata),
			.addr_w     (index),
			.data_wstrb (fill_we ? 4'hf : wstrb),
			.en_w       (fill_we | (word_we & (bank_sel == BSW'(j)))),
			.addr_r     (index),
			.en_r       (lookup),
			.data_r     (bank_r[j])
		);
	end

	// Valid bits, set by fill, cleared by evict.
	cache_valid_array #(
		.CL(CL)
	) valid_i (
		.CLK     (CLK),
		.rst_n   (rst_n),
		.index   (index),
		.set     (fill_we),
		.clear   (evict),
		.valid_q (valid_q)
	);

	// Compare fields captured with the read.
	always_ff @(posedge CLK) begin
		if (lookup) begin
			tag_q      <= tag;
			bank_sel_q <= bank_sel;
		end
	end

	// Hit needs a valid line and a matching tag.
	assign tag_hit = valid_q & (tag_r == tag_q);
	assign rdata   = bank_r[bank_sel_q];

endmodule

//--- rtl/cache_pkg.sv
// ************************************************************
// Shared types for the direct-mapped cache subsystem.
// Imported by wildcard into each cache module header.
// ************************************************************

package cache_pkg;

	// Byte address on processor and memory ports.
	typedef logic [31:0] addr_t;

	// One data word, also one bank entry.
	typedef logic [31:0] word_t;

	// Byte write enables for one word.
	typedef logic [3:0] strb_t;

	// Controller states.
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_FILL_REQ,
		ST_FILL_WAIT,
		ST_FILL_WRITE,
		ST_WT_WAIT,
		ST_RESP
	} cache_state_e;

endpackage

//--- rtl/cache_top.sv
// ************************************************************
// Cache subsystem top: controller plus datapath.
// Processor port on one side, line-wide memory port on the other.
// ************************************************************

`timescale 1ns/100ps

module cache_top
	import cache_pkg::*;
#(
	parameter int BK = 4,
	parameter int CL = 16
) (
	input  logic             CLK,
	input  logic             rst_n,
	input  logic             rd,
	input  logic             wr,
	input  logic             evict,
	input  addr_t            addr,
	input  word_t            wdata,
	input  strb_t            wstrb,
	input  logic             mem_ack,
	input  logic [32*BK-1:0] mem_rdata,
	output word_t            rdata,
	output logic             done,
	output logic             hit,
	output logic             busy,
	output logic             mem_rd,
	output logic             mem_wr,
	output addr_t            mem_addr,
	output word_t            mem_wdata,
	output strb_t            mem_wstrb
);

	// Controller to datapath.
	logic             lookup;
	logic             word_we;
	logic             fill_we;
	logic             mem_evict;
	logic [32*BK-1:0] fill_data;
	addr_t            req_addr;
	word_t            req_wdata;
	strb_t            req_wstrb;

	// Datapath to controller.
	logic             tag_hit;
	addr_t            line_addr;

	cache_ctrl #(
		.BK(BK)
	) ctrl_i (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.rd        (rd),
		.wr        (wr),
		.evict     (evict),
		.addr      (addr),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.tag_hit   (tag_hit),
		.line_addr (line_addr),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata),
		.busy      (busy),
		.done      (done),
		.hit       (hit),
		.lookup    (lookup),
		.word_we   (word_we),
		.fill_we   (fill_we),
		.fill_data (fill_data),
		.mem_rd    (mem_rd),
		.mem_wr    (mem_wr),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_wstrb (mem_wstrb),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.req_wstrb (req_wstrb),
		.mem_evict (mem_evict)
	);

	cache_mem #(
		.BK(BK),
		.CL(CL)
	) mem_i (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.addr      (req_addr),
		.lookup    (lookup),
		.word_we   (word_we),
		.wdata     (req_wdata),
		.wstrb     (req_wstrb),
		.fill_we   (fill_we),
		.fill_data (fill_data),
		.evict     (mem_evict),
		.tag_hit   (tag_hit),
		.rdata     (rdata),
		.line_addr (line_addr)
	);

endmodule

//--- rtl/cache_valid_array.sv
// ************************************************************
// Valid bit per cache line, set on fill, cleared on evict.
// Output is registered to line up with the tag SRAM read.
// ************************************************************

`timescale 1ns/100ps

module cache_valid_array #(
	parameter int CL = 16
) (
	input  logic                  CLK,
	input  logic                  rst_n,
	input  logic [$clog2(CL)-1:0] index,
	input  logic                  set,
	input  logic                  clear,
	output logic                  valid_q
);

	logic [CL-1:0] valid;

	// All lines invalid out of reset.
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
		end else begin
			if (set) begin
				valid[index] <= 1'b1;
			end
			// Fill and evict never overlap.
			if (clear) begin
				valid[index] <= 1'b0;
			end
		end
	end

	// Registered lookup, same edge as the SRAM read.
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= valid[index];
		end
	end

endmodule

//--- rtl/gen_sram.sv
// ************************************************************
// Generic synchronous SRAM, one read and one write port.
// Byte strobes; a partial top byte is allowed.
// ************************************************************

`timescale 1ns/100ps

module gen_sram #(
	parameter int DW = 32,
	parameter int AW = 4
) (
	input  logic                  CLK,
	input  logic [DW-1:0]         data_w,
	input  logic [AW-1:0]         addr_w,
	input  logic [(DW+7)/8-1:0]   data_wstrb,
	input  logic                  en_w,
	input  logic [AW-1:0]         addr_r,
	input  logic                  en_r,
	output logic [DW-1:0]         data_r
);

	// Storage array, no reset.
	logic [DW-1:0] mem [2**AW];
	logic [DW-1:0] wmask;

	// Expand byte strobes into a bit mask.
	always_comb begin
		for (int i = 0; i < DW; i++) begin
			wmask[i] = data_wstrb[i/8];
		end
	end

	// Masked write.
	always_ff @(posedge CLK) begin
		if (en_w) begin
			mem[addr_w] <= (mem[addr_w] & ~wmask) | (data_w & wmask);
		end
	end

	// Read data holds until the next enabled read.
	// Same-address write in the same cycle returns old data.
	always_ff @(posedge CLK) begin
		if (en_r) begin
			data_r <= mem[addr_r];
		end
	end

endmodule

//--- run_sim.sh
#!/bin/bash
# Build the cache testbench with Verilator, run it, and grep the log for the pass line.
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing -f cache_mem.f --top-module cache_tb -o cache_tb_sim \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/cache_tb_sim > "$LOG" 2>&1
cat "$LOG"
grep -q "^NO ERRORS$" "$LOG" && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- verif/cache_tb.sv
// ************************************************************
// Testbench for cache_top: line memory model, stimulus table,
// shadow line state and self-checks; stops at the first error.
// ************************************************************

`timescale 1ns/100ps

module cache_tb
	import cache_pkg::*;
();

	localparam int BK  = 4;
	localparam int CL  = 16;
	localparam int OFS = 2 + $clog2(BK);
	localparam int IW  = $clog2(CL);
	localparam int TW  = 32 - OFS - IW;
	localparam logic [1:0] OP_RD = 2'd0;
	localparam logic [1:0] OP_WR = 2'd1;
	localparam logic [1:0] OP_EV = 2'd2;
	// Line index 5, never cached by the table.
	localparam addr_t STRAY_ADDR = 32'h0000_5050;

	// One table row: operation, request, expected hit, busy strobes.
	typedef struct packed {
		logic [1:0] op;
		addr_t      addr;
		word_t      wdata;
		strb_t      wstrb;
		logic       exp_hit;
		logic       poke;
	} row_t;

	logic             CLK;
	logic             rst_n;
	logic             rd;
	logic             wr;
	logic             evict;
	addr_t            addr;
	word_t            wdata;
	strb_t            wstrb;
	logic             mem_ack;
	logic [32*BK-1:0] mem_rdata;
	word_t            rdata;
	logic             done;
	logic             hit;
	logic             busy;
	logic             mem_rd;
	logic             mem_wr;
	addr_t            mem_addr;
	word_t            mem_wdata;
	strb_t            mem_wstrb;

	row_t             stim [32];
	int               n_rows = 0;
	logic             shadow_valid [CL];
	logic [TW-1:0]    shadow_tag [CL];
	// Written words only; others follow the fill rule.
	word_t            store [addr_t];
	int               rd_reqs = 0;
	int               wr_reqs = 0;
	int               acks = 0;
	addr_t            last_rd_addr;
	addr_t            last_wr_addr;
	word_t            last_wr_data;
	strb_t            last_wr_strb;
	int               cycles = 0;
	int               limit = 100;

	cache_top #(
		.BK(BK),
		.CL(CL)
	) dut_i (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.rd        (rd),
		.wr        (wr),
		.evict     (evict),
		.addr      (addr),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata),
		.rdata     (rdata),
		.done      (done),
		.hit       (hit),
		.busy      (busy),
		.mem_rd    (mem_rd),
		.mem_wr    (mem_wr),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_wstrb (mem_wstrb)
	);

	// 100 ns clock.
	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// Cycle limit against a hung run.
	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles > limit) begin
			$display("Timeout: the run did not finish within %0d cycles.", limit);
			$display("ERRORS FOUND");
			$fatal(1, "run timed out");
		end
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			abort_run($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			abort_run($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_strb(input string name, input strb_t got, input strb_t exp);
		if (got !== exp) begin
			abort_run($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("CHECK FAILED %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			abort_run($sformatf("CHECK FAILED %s: got %0h expected %0h", name, got, exp));
		end
	endtask

	// Inputs change 10 ns after the rising edge.
	task automatic step();
		@(posedge CLK);
		#10;
	endtask

	// Unwritten word: its word address XOR a fixed pattern.
	function automatic word_t model_word(input addr_t a);
		if (store.exists({a[31:2], 2'b00})) begin
			return store[{a[31:2], 2'b00}];
		end
		return (a >> 2) ^ 32'h5a5a_0000;
	endfunction

	function automatic word_t merge_word(input word_t old, input word_t nw, input strb_t s);
		word_t r;
		for (int b = 0; b < 4; b++) begin
			r[8*b +: 8] = s[b] ? nw[8*b +: 8] : old[8*b +: 8];
		end
		return r;
	endfunction

	// Word 0 in the low bits.
	function automatic logic [32*BK-1:0] read_line(input addr_t base);
		logic [32*BK-1:0] line;
		for (int j = 0; j < BK; j++) begin
			line[32*j +: 32] = model_word(base + addr_t'(4 * j));
		end
		return line;
	endfunction

	task automatic put_row(input logic [1:0] op, input addr_t a, input word_t d,
		input strb_t s, input logic h, input logic p);
		stim[n_rows] = {op, a, d, s, h, p};
		n_rows++;
	endtask

	// Index is addr[7:4], tag is addr[31:8].
	task automatic load_stim();
		// Miss, then hits in the same line.
		put_row(OP_RD, 32'h0000_1024, 32'h0, 4'h0, 1'b0, 1'b0);
		put_row(OP_RD, 32'h0000_1028, 32'h0, 4'h0, 1'b1, 1'b0);
		put_row(OP_RD, 32'h0000_102C, 32'h0, 4'h0, 1'b1, 1'b1);
		// Write-through on a hit, partial strobes.
		put_row(OP_WR, 32'h0000_1024, 32'hdead_beef, 4'b0110, 1'b1, 1'b1);
		put_row(OP_RD, 32'h0000_1024, 32'h0, 4'h0, 1'b1, 1'b0);
		// Write miss, no allocate.
		put_row(OP_WR, 32'h0000_2038, 32'h1234_5678, 4'b1001, 1'b0, 1'b0);
		put_row(OP_RD, 32'h0000_2038, 32'h0, 4'h0, 1'b0, 1'b1);
		put_row(OP_RD, 32'h0000_203C, 32'h0, 4'h0, 1'b1, 1'b0);
		// Same index, two tags.
		put_row(OP_RD, 32'h0000_3020, 32'h0, 4'h0, 1'b0, 1'b0);
		put_row(OP_RD, 32'h0000_1020, 32'h0, 4'h0, 1'b0, 1'b0);
		put_row(OP_RD, 32'h0000_3024, 32'h0, 4'h0, 1'b0, 1'b0);
		put_row(OP_RD, 32'h0000_1028, 32'h0, 4'h0, 1'b0, 1'b1);
		// Evicts; other lines keep hitting.
		put_row(OP_EV, 32'h0000_1020, 32'h0, 4'h0, 1'b0, 1'b0);
		put_row(OP_RD, 32'h0000_1024, 32'h0, 4'h0, 1'b0, 1'b0);
		put_row(OP_RD, 32'h0000_2030, 32'h0, 4'h0, 1'b1, 1'b0);
		put_row(OP_EV, 32'h0000_2030, 32'h0, 4'h0, 1'b0, 1'b0);
		put_row(OP_WR, 32'h0000_2034, 32'ha5a5_0f0f, 4'hf, 1'b0, 1'b0);
		put_row(OP_RD, 32'h0000_2034, 32'h0, 4'h0, 1'b0, 1'b0);
		put_row(OP_WR, 32'h0000_2034, 32'h0000_00ff, 4'b0001, 1'b1, 1'b1);
		put_row(OP_RD, 32'h0000_2034, 32'h0, 4'h0, 1'b1, 1'b0);
		put_row(OP_RD, 32'h0001_0040, 32'h0, 4'h0, 1'b0, 1'b0);
		put_row(OP_RD, 32'h0001_004C, 32'h0, 4'h0, 1'b1, 1'b0);
	endtask

	task automatic run_evict(input row_t r);
		logic [IW-1:0] idx;
		idx = r.addr[OFS +: IW];
		addr = r.addr;
		evict = 1'b1;
		step();
		evict = 1'b0;
		shadow_valid[idx] = 1'b0;
		// No response and no busy for an evict.
		check_bit("busy", busy, 1'b0);
		check_bit("done", done, 1'b0);
	endtask

	task automatic run_access(input int i);
		row_t          r;
		logic          is_rd;
		logic          pred;
		int            lat;
		int            rd0;
		int            wr0;
		logic [IW-1:0] idx;
		logic [TW-1:0] tg;
		addr_t         word_a;
		r = stim[i];
		is_rd = (r.op == OP_RD);
		idx = r.addr[OFS +: IW];
		tg = r.addr[31 -: TW];
		word_a = {r.addr[31:2], 2'b00};
		pred = shadow_valid[idx] && (shadow_tag[idx] == tg);
		if (pred !== r.exp_hit) begin
			abort_run($sformatf("Stimulus row %0d expects hit %0b, line state says %0b.",
				i, r.exp_hit, pred));
		end
		while (busy) begin
			step();
		end
		rd0 = rd_reqs;
		wr0 = wr_reqs;
		addr = r.addr;
		wdata = r.wdata;
		wstrb = r.wstrb;
		rd = is_rd;
		wr = !is_rd;
		step();
		rd = 1'b0;
		wr = 1'b0;
		lat = 0;
		while (!done) begin
			check_bit("busy", busy, 1'b1);
			// Strobes while busy must be dropped.
			if (r.poke) begin
				addr = STRAY_ADDR;
				wdata = 32'hffff_ffff;
				wstrb = 4'hf;
				rd = !lat[0];
				wr = lat[0];
			end
			step();
			lat++;
		end
		rd = 1'b0;
		wr = 1'b0;
		check_bit("hit", hit, r.exp_hit);
		check_count("mem_rd requests", rd_reqs - rd0, (is_rd && !r.exp_hit) ? 1 : 0);
		check_count("mem_wr requests", wr_reqs - wr0, is_rd ? 0 : 1);
		check_count("mem_ack pulses", acks, rd_reqs + wr_reqs);
		if (is_rd) begin
			check_word("rdata", rdata, model_word(word_a));
			if (r.exp_hit) begin
				check_count("read hit done latency", lat, 2);
			end else begin
				check_addr("mem_addr", last_rd_addr, {r.addr[31:OFS], {OFS{1'b0}}});
				shadow_valid[idx] = 1'b1;
				shadow_tag[idx] = tg;
			end
		end else begin
			check_addr("mem_addr", last_wr_addr, word_a);
			check_word("mem_wdata", last_wr_data, r.wdata);
			check_strb("mem_wstrb", last_wr_strb, r.wstrb);
		end
		// Busy falls the cycle after done.
		step();
		check_bit("busy", busy, 1'b0);
	endtask

	// Memory model: one request at a time, ack after 1 to 6 cycles.
	initial begin : mem_model
		int    pend;
		logic  pend_rd;
		addr_t pend_addr;
		pend = 0;
		pend_rd = 1'b0;
		pend_addr = '0;
		mem_ack = 1'b0;
		mem_rdata = '0;
		void'($urandom(32'h78985a44));
		forever begin
			@(posedge CLK);
			#10;
			mem_ack = 1'b0;
			if (rst_n && (mem_rd || mem_wr) && (pend > 0 || (mem_rd && mem_wr))) begin
				abort_run("Memory request issued while another one is outstanding.");
			end
			if (pend > 0) begin
				pend = pend - 1;
				if (pend == 0) begin
					if (pend_rd) begin
						mem_rdata = read_line(pend_addr);
					end
					mem_ack = 1'b1;
					acks = acks + 1;
				end
			end else if (rst_n && (mem_rd || mem_wr)) begin
				pend = 1 + int'($urandom % 6);
				pend_rd = mem_rd;
				pend_addr = mem_addr;
				if (mem_rd) begin
					rd_reqs = rd_reqs + 1;
					last_rd_addr = mem_addr;
				end else begin
					wr_reqs = wr_reqs + 1;
					last_wr_addr = mem_addr;
					last_wr_data = mem_wdata;
					last_wr_strb = mem_wstrb;
					// Byte merge into the backing store.
					store[{mem_addr[31:2], 2'b00}] =
						merge_word(model_word(mem_addr), mem_wdata, mem_wstrb);
				end
			end
		end
	end

	initial begin : main
		rst_n = 1'b0;
		rd = 1'b0;
		wr = 1'b0;
		evict = 1'b0;
		addr = '0;
		wdata = '0;
		wstrb = '0;
		for (int i = 0; i < CL; i++) begin
			shadow_valid[i] = 1'b0;
			shadow_tag[i] = '0;
		end
		load_stim();
		limit = n_rows * 20 + 100;
		repeat (5) @(posedge CLK);
		#10;
		rst_n = 1'b1;
		// Quiet outputs out of reset.
		check_bit("done", done, 1'b0);
		check_bit("busy", busy, 1'b0);
		check_bit("mem_rd", mem_rd, 1'b0);
		check_bit("mem_wr", mem_wr, 1'b0);
		for (int i = 0; i < n_rows; i++) begin
			if (stim[i].op == OP_EV) begin
				run_evict(stim[i]);
			end else begin
				run_access(i);
			end
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule
